// File: hw/tcb_amo_pkg.sv
`default_nettype none

package tcb_amo_pkg;

    //////////////////////////////
    // bus geometry
    //////////////////////////////

    // address counted in words, not bytes
    localparam int unsigned ADR_WIDTH = 8;
    // data word width
    localparam int unsigned DAT_WIDTH = 32;
    // words in the memory, upper part of the address space is unmapped
    localparam int unsigned MEM_DEPTH = 192;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // RISC-V AMO function codes (funct5)
    typedef enum logic [4:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_op_t;

    // read-modify-write sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } rmw_state_t;

    //////////////////////////////
    // bus payload
    //////////////////////////////

    // request, driven by the manager
    typedef struct packed {
        logic                 wen;
        logic                 ren;
        logic                 atm;
        amo_op_t              amo;
        logic [ADR_WIDTH-1:0] adr;
        logic [DAT_WIDTH-1:0] wdt;
    } tcb_req_t;

    // response, one cycle after the transfer
    typedef struct packed {
        logic [DAT_WIDTH-1:0] rdt;
        // error status
        logic                 sts;
    } tcb_rsp_t;

endpackage

`default_nettype wire

// File: hw/tcb_amo_alu.sv
`default_nettype none

module tcb_amo_alu (
    input  tcb_amo_pkg::amo_op_t                amo,
    input  logic [tcb_amo_pkg::DAT_WIDTH-1:0]   wdt,
    input  logic [tcb_amo_pkg::DAT_WIDTH-1:0]   rdt,
    output logic [tcb_amo_pkg::DAT_WIDTH-1:0]   res
);

    // difference with carry out, wdt - rdt
    logic [tcb_amo_pkg::DAT_WIDTH:0] dif;
    // unsigned and signed less-than (wdt < rdt)
    logic                            lt_u;
    logic                            lt_s;
    // comparison kind picked by the opcode
    logic                            uns;
    logic                            lt;

    //////////////////////////////
    // shared comparator
    //////////////////////////////

    // two's complement subtraction, one adder for all four min/max ops
    assign dif = {1'b0, wdt} + {1'b0, ~rdt} + 1'b1;

    // no carry out means a borrow, so wdt is below rdt
    assign lt_u = ~dif[tcb_amo_pkg::DAT_WIDTH];

    // differing signs decide directly, the negative one is smaller
    assign lt_s = (wdt[tcb_amo_pkg::DAT_WIDTH-1] != rdt[tcb_amo_pkg::DAT_WIDTH-1])
                ? wdt[tcb_amo_pkg::DAT_WIDTH-1] : lt_u;

    assign uns = (amo == tcb_amo_pkg::AMO_MINU) || (amo == tcb_amo_pkg::AMO_MAXU);
    assign lt  = uns ? lt_u : lt_s;

    //////////////////////////////
    // result select
    //////////////////////////////

    always_comb begin
        case (amo)
            tcb_amo_pkg::AMO_ADD:  res = wdt + rdt;
            tcb_amo_pkg::AMO_XOR:  res = wdt ^ rdt;
            tcb_amo_pkg::AMO_AND:  res = wdt & rdt;
            tcb_amo_pkg::AMO_OR:   res = wdt | rdt;
            // smaller of the two
            tcb_amo_pkg::AMO_MIN,
            tcb_amo_pkg::AMO_MINU: res = lt ? wdt : rdt;
            // larger of the two
            tcb_amo_pkg::AMO_MAX,
            tcb_amo_pkg::AMO_MAXU: res = lt ? rdt : wdt;
            // swap, and anything unknown behaves as swap
            default:               res = wdt;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/tcb_amo_rmw.sv
`default_nettype none

module tcb_amo_rmw (
    input  logic                  clk,
    input  logic                  reset,
    // subordinate port, AMO capable manager connects here
    input  logic                  sub_vld,
    output logic                  sub_rdy,
    input  tcb_amo_pkg::tcb_req_t sub_req,
    output tcb_amo_pkg::tcb_rsp_t sub_rsp,
    // manager port, plain memory connects here
    output logic                  man_vld,
    input  logic                  man_rdy,
    output tcb_amo_pkg::tcb_req_t man_req,
    input  tcb_amo_pkg::tcb_rsp_t man_rsp
);

    // sequencer
    tcb_amo_pkg::rmw_state_t state;
    tcb_amo_pkg::rmw_state_t state_nxt;

    // a plain transfer happened last cycle, its response is on man_rsp now
    logic                    rsp_owed;
    // the AMO finished last cycle, sub_rsp must show the held old word
    logic                    amo_rsp;
    // old word and read status of the AMO
    tcb_amo_pkg::tcb_rsp_t   rsp_old;

    // new word for the write phase
    logic [tcb_amo_pkg::DAT_WIDTH-1:0] alu_res;

    //////////////////////////////
    // modify
    //////////////////////////////

    // operand comes straight from the held request, old word from memory
    tcb_amo_alu u_alu (
        .amo (sub_req.amo),
        .wdt (sub_req.wdt),
        .rdt (man_rsp.rdt),
        .res (alu_res)
    );

    //////////////////////////////
    // request path and FSM
    //////////////////////////////

    always_comb begin
        state_nxt   = state;
        man_vld     = 1'b0;
        sub_rdy     = 1'b0;
        man_req     = sub_req;
        // the memory side never sees an atomic
        man_req.atm = 1'b0;
        case (state)
            tcb_amo_pkg::ST_IDLE: begin
                if (sub_vld && sub_req.atm) begin
                    if (rsp_owed) begin
                        // memory response still due, step aside one cycle
                        state_nxt = tcb_amo_pkg::ST_READ;
                    end else begin
                        // read phase, sub side stalls
                        man_vld     = 1'b1;
                        man_req.wen = 1'b0;
                        man_req.ren = 1'b1;
                        if (man_rdy) begin
                            state_nxt = tcb_amo_pkg::ST_WRITE;
                        end
                    end
                end else begin
                    // plain access, straight through
                    man_vld = sub_vld;
                    sub_rdy = man_rdy;
                end
            end
            tcb_amo_pkg::ST_READ: begin
                // idle cycle on the memory, owed response drains
                state_nxt = tcb_amo_pkg::ST_IDLE;
            end
            tcb_amo_pkg::ST_WRITE: begin
                // write phase, old word is on man_rsp this cycle
                man_vld     = 1'b1;
                man_req.wen = 1'b1;
                man_req.ren = 1'b0;
                man_req.wdt = alu_res;
                // sub transfer completes with the write
                sub_rdy     = man_rdy;
                if (man_rdy) begin
                    state_nxt = tcb_amo_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = tcb_amo_pkg::ST_IDLE;
            end
        endcase
    end

    //////////////////////////////
    // control registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= tcb_amo_pkg::ST_IDLE;
            rsp_owed <= 1'b0;
            amo_rsp  <= 1'b0;
        end else begin
            state    <= state_nxt;
            // only plain transfers complete in idle
            rsp_owed <= (state == tcb_amo_pkg::ST_IDLE) && sub_vld && sub_rdy;
            amo_rsp  <= (state == tcb_amo_pkg::ST_WRITE) && man_rdy;
        end
    end

    // old word and read error, captured during the write phase
    always_ff @(posedge clk) begin
        if (state == tcb_amo_pkg::ST_WRITE) begin
            rsp_old <= man_rsp;
        end
    end

    //////////////////////////////
    // response path
    //////////////////////////////

    // AMO returns the old word, plain accesses see the memory
    assign sub_rsp = amo_rsp ? rsp_old : man_rsp;

endmodule

`default_nettype wire

// File: hw/tcb_mem.sv
`default_nettype none

module tcb_mem (
    input  logic                  clk,
    input  logic                  reset,
    // subordinate port
    input  logic                  vld,
    output logic                  rdy,
    input  tcb_amo_pkg::tcb_req_t req,
    output tcb_amo_pkg::tcb_rsp_t rsp
);

    // storage
    logic [tcb_amo_pkg::DAT_WIDTH-1:0] mem [0:tcb_amo_pkg::MEM_DEPTH-1];

    // address falls inside the array
    logic                              hit;

    // no wait states
    assign rdy = 1'b1;

    assign hit = (req.adr < tcb_amo_pkg::MEM_DEPTH);

    //////////////////////////////
    // write
    //////////////////////////////

    // out of range writes are dropped
    always_ff @(posedge clk) begin
        if (vld && rdy && req.wen && hit) begin
            mem[req.adr] <= req.wdt;
        end
    end

    //////////////////////////////
    // response
    //////////////////////////////

    // registered, valid one cycle after the transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp <= '0;
        end else if (vld && rdy) begin
            // old contents, read before the write lands
            rsp.rdt <= (req.ren && hit) ? mem[req.adr] : '0;
            // error for any unmapped address
            rsp.sts <= ~hit;
        end
    end

endmodule

`default_nettype wire

// File: hw/tcb_amo_top.sv
`default_nettype none

module tcb_amo_top (
    input  logic                  clk,
    input  logic                  reset,
    // external manager
    input  logic                  sub_vld,
    output logic                  sub_rdy,
    input  tcb_amo_pkg::tcb_req_t sub_req,
    output tcb_amo_pkg::tcb_rsp_t sub_rsp
);

    // converter to memory link
    logic                  man_vld;
    logic                  man_rdy;
    tcb_amo_pkg::tcb_req_t man_req;
    tcb_amo_pkg::tcb_rsp_t man_rsp;

    // AMO to read/write split
    tcb_amo_rmw u_rmw (
        .clk     (clk),
        .reset   (reset),
        .sub_vld (sub_vld),
        .sub_rdy (sub_rdy),
        .sub_req (sub_req),
        .sub_rsp (sub_rsp),
        .man_vld (man_vld),
        .man_rdy (man_rdy),
        .man_req (man_req),
        .man_rsp (man_rsp)
    );

    // plain memory
    tcb_mem u_mem (
        .clk   (clk),
        .reset (reset),
        .vld   (man_vld),
        .rdy   (man_rdy),
        .req   (man_req),
        .rsp   (man_rsp)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////
    // free running clock
    //////////////////////////////

    // 40 ns period, low for the first half
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule

`default_nettype wire

// File: sim/tb_tcb_amo_assert.sv
`default_nettype none

module tb_tcb_amo_assert (
    input logic                    clk,
    input logic                    reset,
    input tcb_amo_pkg::rmw_state_t state,
    input logic                    sub_vld,
    input logic                    sub_rdy,
    input tcb_amo_pkg::tcb_req_t   sub_req,
    input logic                    man_vld,
    input tcb_amo_pkg::tcb_req_t   man_req
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////
    // converter FSM
    //////////////////////////////

    // wait state keeps the memory quiet
    a_read_quiet: assert property (@(posedge clk) disable iff (reset)
        (state == tcb_amo_pkg::ST_READ) |-> !man_vld)
        else $error("man_vld high in ST_READ");

    // atomic completes only together with its write phase
    a_amo_with_write: assert property (@(posedge clk) disable iff (reset)
        (sub_vld && sub_rdy && sub_req.atm)
            |-> (state == tcb_amo_pkg::ST_WRITE && man_vld && man_req.wen))
        else $error("atomic sub transfer outside the write phase");

    // memory never stalls, so write phase is a single cycle
    a_write_once: assert property (@(posedge clk) disable iff (reset)
        (state == tcb_amo_pkg::ST_WRITE) |=> (state != tcb_amo_pkg::ST_WRITE))
        else $error("ST_WRITE held for more than one cycle");

endmodule

bind tcb_amo_rmw tb_tcb_amo_assert u_assert (
    .clk     (clk),
    .reset   (reset),
    .state   (state),
    .sub_vld (sub_vld),
    .sub_rdy (sub_rdy),
    .sub_req (sub_req),
    .man_vld (man_vld),
    .man_req (man_req)
);

`default_nettype wire

// File: sim/tb_tcb_amo.sv
`default_nettype none

module tb_tcb_amo;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 40;
    // random transactions after the fill
    localparam int N_TXN       = 400;
    // fill and readback sweeps plus random traffic and slack
    localparam int TIMEOUT_CYC = N_TXN * 4 + 2 * tcb_amo_pkg::MEM_DEPTH + 100;

    typedef logic [tcb_amo_pkg::DAT_WIDTH-1:0] word_t;

    // one expected response and its address for the error line
    typedef struct packed {
        logic [tcb_amo_pkg::ADR_WIDTH-1:0] adr;
        tcb_amo_pkg::tcb_rsp_t             rsp;
    } exp_t;

    logic                  clk;
    logic                  reset;
    logic                  sub_vld;
    logic                  sub_rdy;
    tcb_amo_pkg::tcb_req_t sub_req;
    tcb_amo_pkg::tcb_rsp_t sub_rsp;

    // shadow copy of the memory
    word_t                             shadow [tcb_amo_pkg::MEM_DEPTH];
    exp_t                              exp_q [$];
    logic [31:0]                       rng;
    // previous cycle had a plain transfer
    logic                              last_plain;
    logic [tcb_amo_pkg::ADR_WIDTH-1:0] last_adr;
    int                                n_mismatch;
    int                                n_other;
    int                                n_checked;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    tcb_amo_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .sub_vld (sub_vld),
        .sub_rdy (sub_rdy),
        .sub_req (sub_req),
        .sub_rsp (sub_rsp)
    );

    //////////////////////////////
    // model
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // new memory word from old word and operand by the RISC-V AMO rules
    function automatic word_t amo_model(input tcb_amo_pkg::amo_op_t op,
                                        input word_t old, input word_t opnd);
        case (op)
            tcb_amo_pkg::AMO_ADD:  return old + opnd;
            tcb_amo_pkg::AMO_XOR:  return old ^ opnd;
            tcb_amo_pkg::AMO_AND:  return old & opnd;
            tcb_amo_pkg::AMO_OR:   return old | opnd;
            tcb_amo_pkg::AMO_MIN:  return ($signed(opnd) < $signed(old)) ? opnd : old;
            tcb_amo_pkg::AMO_MAX:  return ($signed(opnd) > $signed(old)) ? opnd : old;
            tcb_amo_pkg::AMO_MINU: return (opnd < old) ? opnd : old;
            tcb_amo_pkg::AMO_MAXU: return (opnd > old) ? opnd : old;
            default:               return opnd;
        endcase
    endfunction

    function automatic tcb_amo_pkg::amo_op_t pick_op(input logic [31:0] r);
        case (r % 9)
            0:       return tcb_amo_pkg::AMO_SWAP;
            1:       return tcb_amo_pkg::AMO_ADD;
            2:       return tcb_amo_pkg::AMO_XOR;
            3:       return tcb_amo_pkg::AMO_AND;
            4:       return tcb_amo_pkg::AMO_OR;
            5:       return tcb_amo_pkg::AMO_MIN;
            6:       return tcb_amo_pkg::AMO_MAX;
            7:       return tcb_amo_pkg::AMO_MINU;
            default: return tcb_amo_pkg::AMO_MAXU;
        endcase
    endfunction

    // initial contents that depend on every address bit
    function automatic word_t fill_word(input logic [31:0] a);
        return (a * 32'h0101_0101) ^ 32'h5ac3_3ca5;
    endfunction

    task automatic roll(output logic [31:0] v);
        rng = xorshift32(rng);
        v   = rng;
    endtask

    //////////////////////////////
    // per cycle check
    //////////////////////////////

    // runs a quarter period before the rising edge when everything has settled
    task automatic cycle_check(output logic hs);
        exp_t e;
        logic hit;
        // response of last cycle's transfer
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            n_checked++;
            if (sub_rsp !== e.rsp) begin
                n_mismatch++;
                $display("MISMATCH t=%0t adr=%02h exp=%08h/%0b got=%08h/%0b",
                         $time, e.adr, e.rsp.rdt, e.rsp.sts, sub_rsp.rdt, sub_rsp.sts);
            end
        end
        hs = sub_vld && sub_rdy;
        if (hs) begin
            hit       = (sub_req.adr < tcb_amo_pkg::MEM_DEPTH);
            e.adr     = sub_req.adr;
            e.rsp.sts = ~hit;
            e.rsp.rdt = '0;
            if (hit) begin
                if (sub_req.atm) begin
                    // old word goes back and the modified word stays
                    e.rsp.rdt           = shadow[sub_req.adr];
                    shadow[sub_req.adr] = amo_model(sub_req.amo, shadow[sub_req.adr],
                                                    sub_req.wdt);
                end else if (sub_req.wen) begin
                    shadow[sub_req.adr] = sub_req.wdt;
                end else begin
                    e.rsp.rdt = shadow[sub_req.adr];
                end
            end
            exp_q.push_back(e);
        end
        last_plain = hs && !sub_req.atm;
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one request held until accepted and its wait count checked
    task automatic send(input tcb_amo_pkg::tcb_req_t r);
        logic hs;
        logic owed;
        int   waits;
        int   want;
        @(negedge clk);
        sub_vld = 1'b1;
        sub_req = r;
        owed    = last_plain;
        waits   = 0;
        #(CLK_PERIOD / 4);
        cycle_check(hs);
        while (!hs) begin
            @(negedge clk);
            waits = waits + 1;
            #(CLK_PERIOD / 4);
            cycle_check(hs);
        end
        // AMO waits one cycle
        // owed plain response adds the idle decision cycle and the ST_READ cycle
        want = r.atm ? (owed ? 3 : 1) : 0;
        if (waits != want) begin
            n_other++;
            $display("ERROR t=%0t adr=%02h: request accepted after %0d wait cycles, not %0d",
                     $time, r.adr, waits, want);
        end
    endtask

    task automatic idle(input int n);
        logic hs;
        repeat (n) begin
            @(negedge clk);
            sub_vld = 1'b0;
            #(CLK_PERIOD / 4);
            cycle_check(hs);
        end
    endtask

    task automatic random_txn();
        logic [31:0]           r;
        logic [31:0]           a;
        logic [31:0]           d;
        tcb_amo_pkg::tcb_req_t req;
        roll(r);
        roll(a);
        roll(d);
        req = '0;
        // about one in ten unmapped and some repeat the last address
        if (a % 10 == 0) begin
            a = tcb_amo_pkg::MEM_DEPTH
              + (a >> 8) % ((1 << tcb_amo_pkg::ADR_WIDTH) - tcb_amo_pkg::MEM_DEPTH);
        end else if (a % 4 == 1) begin
            a = 32'(last_adr);
        end else begin
            a = (a >> 8) % tcb_amo_pkg::MEM_DEPTH;
        end
        req.adr = a[tcb_amo_pkg::ADR_WIDTH-1:0];
        req.wdt = d;
        case (r % 10)
            0, 1, 2: req.wen = 1'b1;
            3, 4, 5: req.ren = 1'b1;
            default: begin
                req.wen = 1'b1;
                req.ren = 1'b1;
                req.atm = 1'b1;
                req.amo = pick_op(r >> 8);
                // operand with the opposite sign of the stored word
                if (r[20] && a < tcb_amo_pkg::MEM_DEPTH) begin
                    req.wdt[tcb_amo_pkg::DAT_WIDTH-1] = ~shadow[a][tcb_amo_pkg::DAT_WIDTH-1];
                end
            end
        endcase
        last_adr = req.adr;
        send(req);
        // random bubbles but often none so traffic runs back to back
        roll(r);
        if (r[1:0] == 2'b00) begin
            idle(r[2] ? 2 : 1);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int                    i;
        logic [31:0]           a32;
        tcb_amo_pkg::tcb_req_t req;
        rng        = 32'd17;
        n_mismatch = 0;
        n_other    = 0;
        n_checked  = 0;
        last_plain = 1'b0;
        last_adr   = '0;
        reset      = 1'b1;
        sub_vld    = 1'b0;
        sub_req    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // fill every word and each write must answer cleanly
        for (i = 0; i < tcb_amo_pkg::MEM_DEPTH; i++) begin
            a32     = i;
            req     = '0;
            req.wen = 1'b1;
            req.adr = a32[tcb_amo_pkg::ADR_WIDTH-1:0];
            req.wdt = fill_word(a32);
            send(req);
        end
        for (i = 0; i < N_TXN; i++) begin
            random_txn();
        end
        // final sweep catches stray writes anywhere
        for (i = 0; i < tcb_amo_pkg::MEM_DEPTH; i++) begin
            a32     = i;
            req     = '0;
            req.ren = 1'b1;
            req.adr = a32[tcb_amo_pkg::ADR_WIDTH-1:0];
            send(req);
        end
        idle(2);
        $display("errors: %0d mismatches, %0d protocol, %0d responses checked",
                 n_mismatch, n_other, n_checked);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("timeout: no end of test after %0d cycles, the DUT stopped responding",
                 TIMEOUT_CYC);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hw/tcb_amo_pkg.sv
hw/tcb_amo_alu.sv
hw/tcb_amo_rmw.sv
hw/tcb_mem.sv
hw/tcb_amo_top.sv
sim/tb_clock_gen.sv
sim/tb_tcb_amo_assert.sv
sim/tb_tcb_amo.sv

// File: Makefile
# Verilator build and run for the AMO converter testbench

VERILATOR ?= verilator
TOP       ?= tb_tcb_amo
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation incomplete"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
